// ==== Makefile ====
# Verilator flow for the nibble bus model.
# Run from the project root so the ROM image path resolves.

TOP = saturn_bus_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f flist.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== flist.f ====
logic/saturn_pkg.sv
logic/saturn_rom.sv
logic/saturn_bus_controller.sv
logic/saturn_debug_printer.sv
logic/saturn_bus.sv
testbench/saturn_bus_tb.sv

// ==== logic/saturn_bus.sv ====
`timescale 1ns/1ns

module saturn_bus import saturn_pkg::*; (
    input  logic        i_clk,
    input  logic        i_clk_en,
    input  logic        i_reset,
    input  logic        i_serial_busy,
    output logic        o_halt,
    output logic [1:0]  o_phase,
    output logic [31:0] o_cycle_ctr,
    output logic [7:0]  o_char_to_send,
    output logic [9:0]  o_char_counter,
    output logic        o_char_valid,
    output logic        o_char_send
);

    // One-hot bus phase and its binary form.
    logic [3:0]  phases;
    logic [1:0]  phase;
    logic [31:0] cycle_ctr;
    logic        phase_adv;

    // Nibble bus between controller and ROM.
    logic        bus_strobe;
    logic        bus_is_data;
    bus_nibble_u bus_nibble_out;
    logic [3:0]  rom_nibble;

    // Controller to printer link.
    logic        prn_put;
    logic [3:0]  prn_nibble;
    logic        prn_last;
    logic        prn_full;
    logic        prn_done;

    logic        debug_stall;
    logic        ctrl_halt;

    // Phases move only when enabled and the printer keeps up.
    assign phase_adv = i_clk_en && !debug_stall;

    // One-hot to binary.
    always_comb begin
        phase = 2'd0;
        if (phases[1]) phase = 2'd1;
        if (phases[2]) phase = 2'd2;
        if (phases[3]) phase = 2'd3;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            phases    <= 4'b0001;
            cycle_ctr <= 32'd0;
        end else if (phase_adv) begin
            phases <= {phases[2:0], phases[3]};
            // Phase 3 wraps to 0 and starts a new bus cycle.
            if (phases[3]) cycle_ctr <= cycle_ctr + 32'd1;
        end
    end

    assign o_phase     = phase;
    assign o_cycle_ctr = cycle_ctr;
    assign o_halt      = ctrl_halt;

    // Firmware ROM.
    saturn_rom rom (
        .i_clk        (i_clk),
        .i_clk_en     (i_clk_en),
        .i_reset      (i_reset),
        .i_phase      (phase),
        .i_bus_strobe (bus_strobe),
        .i_bus_is_data(bus_is_data),
        .i_bus_nibble (bus_nibble_out),
        .o_bus_nibble (rom_nibble)
    );

    // Stands in for the CPU.
    saturn_bus_controller bus_controller (
        .i_clk        (i_clk),
        .i_clk_en     (i_clk_en),
        .i_reset      (i_reset),
        .i_phase      (phase),
        .i_bus_nibble (rom_nibble),
        .i_prn_full   (prn_full),
        .i_prn_done   (prn_done),
        .o_bus_strobe (bus_strobe),
        .o_bus_is_data(bus_is_data),
        .o_bus_nibble (bus_nibble_out),
        .o_prn_put    (prn_put),
        .o_prn_nibble (prn_nibble),
        .o_prn_last   (prn_last),
        .o_debug_stall(debug_stall),
        .o_halt       (ctrl_halt)
    );

    // Hex dump to the serial port.
    saturn_debug_printer debug_printer (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_put         (prn_put),
        .i_nibble      (prn_nibble),
        .i_last        (prn_last),
        .i_serial_busy (i_serial_busy),
        .o_full        (prn_full),
        .o_done        (prn_done),
        .o_char_to_send(o_char_to_send),
        .o_char_valid  (o_char_valid),
        .o_char_send   (o_char_send),
        .o_char_counter(o_char_counter)
    );

endmodule

// ==== logic/saturn_bus_controller.sv ====
`timescale 1ns/1ns

module saturn_bus_controller import saturn_pkg::*; (
    input  logic        i_clk,
    input  logic        i_clk_en,
    input  logic        i_reset,
    input  logic [1:0]  i_phase,
    input  logic [3:0]  i_bus_nibble,
    input  logic        i_prn_full,
    input  logic        i_prn_done,
    output logic        o_bus_strobe,
    output logic        o_bus_is_data,
    output bus_nibble_u o_bus_nibble,
    output logic        o_prn_put,
    output logic [3:0]  o_prn_nibble,
    output logic        o_prn_last,
    output logic        o_debug_stall,
    output logic        o_halt
);

    logic [2:0] state;
    logic [2:0] addr_idx;
    logic [9:0] read_cnt;

    // One-nibble holding register toward the printer.
    logic [3:0] hold_nibble;
    logic       hold_last;
    logic       hold_valid;

    logic       on_bus;
    logic       xfer;
    logic       last_read;

    // Printer still busy with the previous character.
    assign o_debug_stall = hold_valid && i_prn_full;

    // Hand over as soon as the printer has room.
    assign o_prn_put    = hold_valid && !i_prn_full;
    assign o_prn_nibble = hold_nibble;
    assign o_prn_last   = hold_last;

    assign o_halt = (state == ST_HALT);

    assign last_read = (read_cnt == READ_COUNT - 10'd1);

    // States that own a bus transfer.
    assign on_bus = (state == ST_LOAD_CMD) || (state == ST_LOAD_ADDR) ||
                    (state == ST_READ_CMD) || (state == ST_READ);

    // Strobe only in phase 1 and never while stalled.
    assign o_bus_strobe = on_bus && (i_phase == 2'd1) && !o_debug_stall;
    assign xfer         = o_bus_strobe && i_clk_en;

    // Bus nibble per state.
    always_comb begin
        o_bus_is_data     = 1'b0;
        o_bus_nibble.data = 4'h0;
        case (state)
            ST_LOAD_CMD: begin
                o_bus_nibble.cmd = CMD_LOAD_PC;
            end
            ST_LOAD_ADDR: begin
                o_bus_is_data     = 1'b1;
                o_bus_nibble.data = START_ADDR[{addr_idx, 2'b00} +: 4];
            end
            ST_READ_CMD: begin
                o_bus_nibble.cmd = CMD_PC_READ;
            end
            ST_READ: begin
                // ROM drives the data.
                o_bus_is_data = 1'b1;
            end
            default: ;
        endcase
    end

    // Transaction FSM.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state      <= ST_LOAD_CMD;
            addr_idx   <= 3'd0;
            read_cnt   <= 10'd0;
            hold_valid <= 1'b0;
        end else begin
            if (o_prn_put) hold_valid <= 1'b0;
            case (state)
                ST_LOAD_CMD: begin
                    if (xfer) begin
                        state    <= ST_LOAD_ADDR;
                        addr_idx <= 3'd0;
                    end
                end
                ST_LOAD_ADDR: begin
                    if (xfer) begin
                        addr_idx <= addr_idx + 3'd1;
                        if (addr_idx == 3'(ADDR_NIBBLES - 1)) state <= ST_READ_CMD;
                    end
                end
                ST_READ_CMD: begin
                    if (xfer) begin
                        state    <= ST_READ;
                        read_cnt <= 10'd0;
                    end
                end
                ST_READ: begin
                    if (xfer) begin
                        // Refill wins over the handover on the same clock.
                        hold_valid <= 1'b1;
                        read_cnt   <= read_cnt + 10'd1;
                        if (last_read) state <= ST_WAIT_DONE;
                    end
                end
                ST_WAIT_DONE: begin
                    // Newline has gone out.
                    if (i_prn_done) state <= ST_HALT;
                end
                ST_HALT: ;
                default: state <= ST_LOAD_CMD;
            endcase
        end
    end

    // Capture the read nibble.
    always_ff @(posedge i_clk) begin
        if (state == ST_READ && xfer) begin
            hold_nibble <= i_bus_nibble;
            hold_last   <= last_read;
        end
    end

endmodule

// ==== logic/saturn_debug_printer.sv ====
`timescale 1ns/1ns

module saturn_debug_printer (
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_put,
    input  logic [3:0] i_nibble,
    input  logic       i_last,
    input  logic       i_serial_busy,
    output logic       o_full,
    output logic       o_done,
    output logic [7:0] o_char_to_send,
    output logic       o_char_valid,
    output logic       o_char_send,
    output logic [9:0] o_char_counter
);

    logic [7:0] char_q;
    logic       char_valid;
    logic       nl_pending;
    logic       nl_active;
    logic       done_q;
    logic [9:0] char_ctr;
    logic [7:0] hex_ascii;
    logic       send;

    // Nibble to '0'..'9' or 'A'..'F'.
    always_comb begin
        if (i_nibble < 4'd10) hex_ascii = {4'h3, i_nibble};
        else hex_ascii = 8'h37 + {4'h0, i_nibble};
    end

    // Send on the first free clock.
    assign send = char_valid && !i_serial_busy;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            char_valid <= 1'b0;
            nl_pending <= 1'b0;
            nl_active  <= 1'b0;
            done_q     <= 1'b0;
            char_ctr   <= 10'd0;
        end else begin
            done_q <= 1'b0;
            if (send) char_ctr <= char_ctr + 10'd1;
            if (i_put) begin
                char_valid <= 1'b1;
                nl_pending <= i_last;
                nl_active  <= 1'b0;
            end else if (send) begin
                if (nl_pending) begin
                    // Newline follows the last digit.
                    nl_pending <= 1'b0;
                    nl_active  <= 1'b1;
                end else begin
                    char_valid <= 1'b0;
                    nl_active  <= 1'b0;
                    done_q     <= nl_active;
                end
            end
        end
    end

    // Character buffer.
    always_ff @(posedge i_clk) begin
        if (i_put) char_q <= hex_ascii;
        else if (send && nl_pending) char_q <= 8'h0a;
    end

    assign o_full         = char_valid;
    assign o_done         = done_q;
    assign o_char_to_send = char_q;
    assign o_char_valid   = char_valid;
    assign o_char_send    = send;
    assign o_char_counter = char_ctr;

endmodule

// ==== logic/saturn_pkg.sv ====
package saturn_pkg;

    // Commands understood on the nibble bus.
    // Only pointer load and pointer read are modelled.
    typedef enum logic [3:0] {
        CMD_PC_READ = 4'd2,
        CMD_LOAD_PC = 4'd4
    } bus_cmd_e;

    // One bus nibble seen two ways.
    // Is-data low means a command.
    // Is-data high means a plain data nibble.
    typedef union packed {
        bus_cmd_e   cmd;
        logic [3:0] data;
    } bus_nibble_u;

    // Firmware ROM geometry.
    localparam int ROM_ADDR_W = 20;
    localparam int ROM_DEPTH = 256;
    localparam string ROM_FILE = "saturn_rom.hex";

    // Address loaded into the ROM pointer after reset.
    localparam logic [ROM_ADDR_W-1:0] START_ADDR = 20'd16;

    // Nibbles read and printed in one run.
    localparam logic [9:0] READ_COUNT = 10'd40;

    // Address nibbles following a load-pointer command.
    localparam int ADDR_NIBBLES = 5;

    // Bus controller states.
    // Send the load-pointer command.
    localparam logic [2:0] ST_LOAD_CMD = 3'd0;
    // Send the address with the low nibble first.
    localparam logic [2:0] ST_LOAD_ADDR = 3'd1;
    // Switch the ROM to pointer reads.
    localparam logic [2:0] ST_READ_CMD = 3'd2;
    // Read transfers, one per bus cycle.
    localparam logic [2:0] ST_READ = 3'd3;
    // Last nibble handed over and waiting for the newline.
    localparam logic [2:0] ST_WAIT_DONE = 3'd4;
    // Run complete.
    localparam logic [2:0] ST_HALT = 3'd5;

endpackage

// ==== logic/saturn_rom.sv ====
`timescale 1ns/1ns

module saturn_rom import saturn_pkg::*; (
    input  logic        i_clk,
    input  logic        i_clk_en,
    input  logic        i_reset,
    input  logic [1:0]  i_phase,
    input  logic        i_bus_strobe,
    input  logic        i_bus_is_data,
    input  bus_nibble_u i_bus_nibble,
    output logic [3:0]  o_bus_nibble
);

    // Firmware image, one nibble per word.
    logic [3:0] mem [ROM_DEPTH];

    // Address pointer and access mode.
    logic [ROM_ADDR_W-1:0] pointer;
    logic                  load_mode;
    logic                  read_mode;
    logic [2:0]            addr_cnt;
    logic                  xfer;

    initial begin
        $readmemh(ROM_FILE, mem);
    end

    // Transfer slot.
    // Strobe in phase 1 on an enabled clock.
    assign xfer = i_bus_strobe && (i_phase == 2'd1) && i_clk_en;

    // Nibble at the pointer with no latency.
    // Upper pointer bits wrap onto the image.
    assign o_bus_nibble = read_mode ? mem[pointer[$clog2(ROM_DEPTH)-1:0]] : 4'h0;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pointer   <= '0;
            load_mode <= 1'b0;
            read_mode <= 1'b0;
            addr_cnt  <= 3'd0;
        end else if (xfer) begin
            if (!i_bus_is_data) begin
                // Command nibble.
                case (i_bus_nibble.cmd)
                    CMD_LOAD_PC: begin
                        load_mode <= 1'b1;
                        read_mode <= 1'b0;
                        addr_cnt  <= 3'd0;
                    end
                    CMD_PC_READ: begin
                        load_mode <= 1'b0;
                        read_mode <= 1'b1;
                    end
                    // Anything else leaves the mode alone.
                    default: ;
                endcase
            end else if (load_mode) begin
                // Address nibble, least significant first.
                pointer[{addr_cnt, 2'b00} +: 4] <= i_bus_nibble.data;
                addr_cnt <= addr_cnt + 3'd1;
                if (addr_cnt == 3'(ADDR_NIBBLES - 1)) begin
                    load_mode <= 1'b0;
                end
            end else if (read_mode) begin
                // Controller took the nibble so step on.
                pointer <= pointer + 1'b1;
            end
        end
    end

endmodule

// ==== saturn_rom.hex ====
// Firmware ROM image, four hex nibbles per line.
// Line n holds addresses 4n to 4n+3, from address 0 up to 63.
0 1 2 3
4 5 6 7
8 9 A B
C D E F
3 A 7 F
0 C 5 9
E 1 B 4
8 2 D 6
F 0 A 3
9 7 C 1
5 E 2 B
6 D 8 4
1 F 3 9
A 0 E 7
2 C 5 D
B 8 4 6

// ==== testbench/saturn_bus_tb.sv ====
`timescale 1ns/1ns

module saturn_bus_tb import saturn_pkg::*;;

    localparam int TIMEOUT_CYCLES = 20000;
    localparam int TAIL_CYCLES = 40;

    logic        i_clk;
    logic        i_clk_en;
    logic        i_reset;
    logic        i_serial_busy;
    logic        o_halt;
    logic [1:0]  o_phase;
    logic [31:0] o_cycle_ctr;
    logic [7:0]  o_char_to_send;
    logic [9:0]  o_char_counter;
    logic        o_char_valid;
    logic        o_char_send;

    // Copy of the firmware image for the reference model.
    logic [3:0] image [256];

    // Random state and busy burst length.
    logic [31:0] rnd;
    int          busy_left;

    // Checker state from the previous falling edge.
    logic        checking;
    logic [1:0]  prev_phase;
    logic [1:0]  next_phase;
    logic [31:0] prev_cycle;
    logic        prev_en;
    logic        prev_valid;
    logic        prev_send;
    logic        prev_halt;
    logic [7:0]  prev_char;

    int err_count;
    int sent_count;
    int cycles;
    logic timed_out;

    saturn_bus UUT (
        .i_clk         (i_clk),
        .i_clk_en      (i_clk_en),
        .i_reset       (i_reset),
        .i_serial_busy (i_serial_busy),
        .o_halt        (o_halt),
        .o_phase       (o_phase),
        .o_cycle_ctr   (o_cycle_ctr),
        .o_char_to_send(o_char_to_send),
        .o_char_counter(o_char_counter),
        .o_char_valid  (o_char_valid),
        .o_char_send   (o_char_send)
    );

    // 40 ns clock.
    always #20 i_clk = ~i_clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Expected character number k of the dump.
    // Digits first, then one closing newline.
    function automatic logic [7:0] expected_char(input int k);
        logic [3:0] nib;
        int         addr;
        if (k == int'(READ_COUNT)) return 8'h0a;
        addr = int'(START_ADDR) + k;
        nib = image[addr];
        if (nib < 4'd10) return 8'h30 + {4'h0, nib};
        return 8'h41 + {4'h0, nib} - 8'd10;
    endfunction

    // Random enable, about 3 in 4 clocks.
    // Busy comes in bursts of 0 to 6 clocks.
    always @(posedge i_clk) begin
        rnd = xorshift(rnd);
        i_clk_en <= (rnd[1:0] != 2'b00);
        if (busy_left > 0) begin
            i_serial_busy <= 1'b1;
            busy_left = busy_left - 1;
        end else begin
            i_serial_busy <= 1'b0;
            if (rnd[7:4] < 4'd3) busy_left = int'(rnd[15:8]) % 7;
        end
    end

    // Compare on the falling edge, where everything has settled.
    always @(negedge i_clk) begin
        next_phase = prev_phase + 2'd1;
        if (checking) begin
            // Phase may only move on an enabled clock.
            if (!prev_en && o_phase != prev_phase) begin
                $display("ERR %0t: phase moved %0d to %0d with enable low",
                         $time, prev_phase, o_phase);
                err_count++;
            end
            // Held phase on an enabled clock means a debug stall.
            if (prev_en && o_phase != next_phase &&
                !(o_phase == prev_phase && prev_valid)) begin
                $display("ERR %0t: phase %0d to %0d, stall without held char",
                         $time, prev_phase, o_phase);
                err_count++;
            end
            if (prev_phase == 2'd3 && o_phase == 2'd0) begin
                if (o_cycle_ctr != prev_cycle + 32'd1) begin
                    $display("ERR %0t: cycle counter %0d, expected %0d",
                             $time, o_cycle_ctr, prev_cycle + 32'd1);
                    err_count++;
                end
            end else if (o_cycle_ctr != prev_cycle) begin
                $display("ERR %0t: cycle counter changed to %0d off the wrap",
                         $time, o_cycle_ctr);
                err_count++;
            end
            // Character must hold while it waits.
            if (prev_valid && o_char_valid && !prev_send && o_char_to_send != prev_char) begin
                $display("ERR %0t: held char changed %h to %h",
                         $time, prev_char, o_char_to_send);
                err_count++;
            end
            if (o_char_counter != 10'(sent_count)) begin
                $display("ERR %0t: char counter %0d, expected %0d",
                         $time, o_char_counter, sent_count);
                err_count++;
            end
            if (prev_halt && !o_halt) begin
                $display("ERR %0t: halt dropped", $time);
                err_count++;
            end
            if (o_halt && sent_count != int'(READ_COUNT) + 1) begin
                $display("ERR %0t: halt after %0d chars", $time, sent_count);
                err_count++;
            end
            if (o_char_send) begin
                if (i_serial_busy) begin
                    $display("ERR %0t: send while serial busy", $time);
                    err_count++;
                end
                if (o_halt) begin
                    $display("ERR %0t: send after halt", $time);
                    err_count++;
                end
                if (sent_count > int'(READ_COUNT)) begin
                    $display("ERR %0t: extra char %h", $time, o_char_to_send);
                    err_count++;
                end else if (o_char_to_send != expected_char(sent_count)) begin
                    $display("ERR %0t: char %0d is %h, expected %h", $time,
                             sent_count, o_char_to_send, expected_char(sent_count));
                    err_count++;
                end
                sent_count++;
            end
        end
        prev_phase = o_phase;
        prev_cycle = o_cycle_ctr;
        prev_en    = i_clk_en;
        prev_valid = o_char_valid;
        prev_send  = o_char_send;
        prev_halt  = o_halt;
        prev_char  = o_char_to_send;
    end

    initial begin
        i_clk         = 1'b0;
        i_reset       = 1'b1;
        i_clk_en      = 1'b0;
        i_serial_busy = 1'b0;
        rnd           = 32'hc5c4299f;
        busy_left     = 0;
        checking      = 1'b0;
        err_count     = 0;
        sent_count    = 0;
        timed_out     = 1'b0;
        $readmemh("saturn_rom.hex", image);

        // Reset for 5 clocks.
        repeat (5) @(posedge i_clk);
        i_reset <= 1'b0;
        @(negedge i_clk);

        // State right after reset.
        if (o_phase != 2'd0 || o_cycle_ctr != 32'd0 || o_halt || o_char_valid ||
            o_char_send || o_char_counter != 10'd0) begin
            $display("ERR %0t: bad state after reset", $time);
            err_count++;
        end
        checking <= 1'b1;

        // Run until halt.
        cycles = 0;
        while (!o_halt && cycles < TIMEOUT_CYCLES) begin
            @(negedge i_clk);
            cycles++;
        end

        if (!o_halt) begin
            timed_out = 1'b1;
            $display("Timeout: o_halt did not rise within %0d clocks", TIMEOUT_CYCLES);
        end else begin
            // Nothing may follow the halt.
            repeat (TAIL_CYCLES) @(negedge i_clk);
            if (sent_count != int'(READ_COUNT) + 1) begin
                $display("ERR %0t: %0d chars sent, expected %0d",
                         $time, sent_count, int'(READ_COUNT) + 1);
                err_count++;
            end
        end

        $display("Summary: %0d errors, %0d chars sent, %0d timeouts",
                 err_count, sent_count, timed_out ? 1 : 0);
        if (err_count == 0 && !timed_out) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
